// File: Bender.yml
package:
  name: word_buffer

sources:
  - src/word_pkg.sv
  - src/buf_pkg.sv
  - src/bank_if.sv
  - src/wordwise_bram.sv
  - src/vector_loader.sv
  - src/vector_streamer.sv
  - src/word_buffer_top.sv
  - target: test
    files:
      - verification/word_buffer_model.sv
      - verification/tb_word_buffer.sv

// File: project.f
src/word_pkg.sv
src/buf_pkg.sv
src/bank_if.sv
src/wordwise_bram.sv
src/vector_loader.sv
src/vector_streamer.sv
src/word_buffer_top.sv
verification/word_buffer_model.sv
verification/tb_word_buffer.sv

// File: src/bank_if.sv
`timescale 1ns/1ps

interface bank_if;
   import word_pkg::*;
   import buf_pkg::*;

   // port A, write only
   loc_addr_t         wr_addr;
   word_t [LANES-1:0] wr_data;
   lane_we_t          wr_we;    // per word, zero means no write

   // port B, registered read
   loc_addr_t         rd_addr;
   word_t [LANES-1:0] rd_data;

   modport loader (
      output wr_addr,
      output wr_data,
      output wr_we
   );

   modport streamer (
      output rd_addr,
      input  rd_data
   );

   modport bank (
      input  wr_addr,
      input  wr_data,
      input  wr_we,
      input  rd_addr,
      output rd_data
   );

endinterface

// File: src/buf_pkg.sv
package buf_pkg;

   // location address inside one bank
   localparam int LOC_AW = 4;
   typedef logic [LOC_AW-1:0] loc_addr_t;

   // lane select inside a location
   localparam int LANE_AW = $clog2(word_pkg::LANES);
   typedef logic [LANE_AW-1:0] lane_idx_t;

   localparam int DEF_BANKS = 4;

   // bank field width, zero for a single bank
   function automatic int bank_aw(input int num_banks);
      return $clog2(num_banks);
   endfunction

   // flat word address is {location, bank, lane} from the top bit down
   function automatic int word_aw(input int num_banks);
      return LOC_AW + bank_aw(num_banks) + LANE_AW;
   endfunction

   localparam int WORD_AW = word_aw(DEF_BANKS);   // 8 bits with 4 banks
   typedef logic [WORD_AW-1:0] word_addr_t;

endpackage

// File: src/vector_loader.sv
`timescale 1ns/1ps

module vector_loader #(
   parameter int NUM_BANKS = 4
) (
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  logic                                   load_start,
   input  logic [buf_pkg::word_aw(NUM_BANKS)-1:0] load_addr,
   input  logic                                   load_valid,
   input  word_pkg::word_t                        load_data,
   bank_if.loader                                 banks [NUM_BANKS]
);
   import word_pkg::*;
   import buf_pkg::*;

   localparam int ADDR_W     = word_aw(NUM_BANKS);
   localparam int BANK_AW    = bank_aw(NUM_BANKS);
   localparam int BANK_SEL_W = (BANK_AW > 0) ? BANK_AW : 1;

   typedef logic [ADDR_W-1:0]     ptr_t;
   typedef logic [BANK_SEL_W-1:0] bank_sel_t;

   ptr_t      ptr;       // next word of the burst
   ptr_t      wr_ptr;    // address used by this cycle's word
   bank_sel_t wr_bank;
   lane_idx_t wr_lane;
   loc_addr_t wr_loc;

   loc_addr_t            addr_q;   // shared by all banks, only we differs
   word_t [LANES-1:0]    data_q;
   logic [NUM_BANKS-1:0] bank_hit;

   // a start in the same cycle redirects the word to the new address
   assign wr_ptr  = load_start ? load_addr : ptr;
   assign wr_lane = wr_ptr[LANE_AW-1:0];
   assign wr_loc  = wr_ptr[ADDR_W-1 -: LOC_AW];
   assign wr_bank = bank_sel_t'((wr_ptr >> LANE_AW) & ptr_t'(NUM_BANKS - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr <= '0;
      end else if (load_valid) begin
         ptr <= wr_ptr + 1'b1;   // wraps at the top of the word space
      end else if (load_start) begin
         ptr <= load_addr;
      end
   end

   // word is copied to every lane, the enable picks the one that lands
   always_ff @(posedge clk) begin
      if (load_valid) begin
         addr_q <= wr_loc;
         data_q <= {LANES{load_data}};
      end
   end

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      lane_we_t we_q;

      always_ff @(posedge clk or negedge arst_n) begin
         if (!arst_n) begin
            we_q <= '0;
         end else if (load_valid && (wr_bank == bank_sel_t'(b))) begin
            we_q <= lane_we_t'(1) << wr_lane;   // one-hot lane
         end else begin
            we_q <= '0;
         end
      end

      assign bank_hit[b]      = |we_q;
      assign banks[b].wr_addr = addr_q;
      assign banks[b].wr_data = data_q;
      assign banks[b].wr_we   = we_q;
   end

   // the word stream never reaches two banks at once
   a_one_bank: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(bank_hit))
      else $error("more than one bank written in one cycle");

endmodule

// File: src/vector_streamer.sv
`timescale 1ns/1ps

module vector_streamer #(
   parameter int NUM_BANKS = 4
) (
   input  logic                                     clk,
   input  logic                                     arst_n,
   input  logic                                     rd_start,
   input  buf_pkg::loc_addr_t                       rd_loc,
   bank_if.streamer                                 banks [NUM_BANKS],
   output logic                                     out_valid,
   output logic                                     out_last,
   output word_pkg::word_t [word_pkg::LANES-1:0]    out_data,
   output logic                                     busy
);
   import word_pkg::*;
   import buf_pkg::*;

   localparam int BEAT_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

   typedef logic [BEAT_W-1:0] beat_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_EMIT
   } stream_state_t;

   stream_state_t     state;
   beat_t             beat;        // fetch step, then beat index
   loc_addr_t         rd_addr_q;
   word_t [LANES-1:0] rd_words [NUM_BANKS];   // all bank outputs side by side
   word_t [LANES-1:0] snap [NUM_BANKS];
   logic              capture;
   logic              last_beat;

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      assign banks[b].rd_addr = rd_addr_q;   // same location in every bank
      assign rd_words[b]      = banks[b].rd_data;
   end

   // second fetch cycle, bank outputs hold the location read one edge earlier
   assign capture   = (state == ST_FETCH) && (beat != '0);
   assign last_beat = (beat == beat_t'(NUM_BANKS - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         beat      <= '0;
         rd_addr_q <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (rd_start) begin
                  rd_addr_q <= rd_loc;
                  beat      <= '0;
                  state     <= ST_FETCH;
               end
            end
            ST_FETCH: begin
               if (capture) begin
                  beat  <= '0;
                  state <= ST_EMIT;
               end else begin
                  beat <= beat_t'(1);   // banks register the location now
               end
            end
            ST_EMIT: begin
               if (last_beat) begin
                  beat  <= '0;
                  state <= ST_IDLE;
               end else begin
                  beat <= beat + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // snapshot of all banks, drained from the bottom one bank per beat
   always_ff @(posedge clk) begin
      if (capture) begin
         snap <= rd_words;
      end else if (state == ST_EMIT) begin
         for (int k = 0; k < NUM_BANKS - 1; k++) begin
            snap[k] <= snap[k+1];
         end
      end
   end

   assign out_valid = (state == ST_EMIT);
   assign out_last  = out_valid && last_beat;
   assign out_data  = snap[0];
   assign busy      = (state != ST_IDLE);   // rd_start is ignored while high

   // last beat closes the frame
   a_last_closes: assert property (
      @(posedge clk) disable iff (!arst_n) out_last |-> out_valid ##1 !out_valid
   ) else $error("out_last outside a frame or not final");

   a_frame_len: assert property (
      @(posedge clk) disable iff (!arst_n)
         $rose(out_valid) |-> out_valid [*NUM_BANKS] ##1 !out_valid
   ) else $error("frame length differs from NUM_BANKS");

   // first beat is driven by the second edge after an accepted start
   a_start_latency: assert property (
      @(posedge clk) disable iff (!arst_n) (rd_start && !busy) |-> ##3 $rose(out_valid)
   ) else $error("first beat not two cycles after start");

endmodule

// File: src/word_buffer_top.sv
`timescale 1ns/1ps

module word_buffer_top #(
   parameter int NUM_BANKS = 4   // power of two, 1 to 8
) (
   input  logic                                   clk,
   input  logic                                   arst_n,

   // burst load side
   input  logic                                   load_start,
   input  logic [buf_pkg::word_aw(NUM_BANKS)-1:0] load_addr,
   input  logic                                   load_valid,
   input  word_pkg::word_t                        load_data,

   // read stream side
   input  logic                                   rd_start,
   input  buf_pkg::loc_addr_t                     rd_loc,
   output logic                                   out_valid,
   output logic                                   out_last,
   output word_pkg::word_t [word_pkg::LANES-1:0]  out_data,
   output logic                                   busy
);

   // one bus per bank, shared by loader, bank and streamer
   bank_if u_bank_if [NUM_BANKS] ();

   vector_loader #(
      .NUM_BANKS (NUM_BANKS)
   ) u_vector_loader (
      .clk        (clk),
      .arst_n     (arst_n),
      .load_start (load_start),
      .load_addr  (load_addr),
      .load_valid (load_valid),
      .load_data  (load_data),
      .banks      (u_bank_if)
   );

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      wordwise_bram u_wordwise_bram (
         .clk  (clk),
         .port (u_bank_if[b])
      );
   end

   vector_streamer #(
      .NUM_BANKS (NUM_BANKS)
   ) u_vector_streamer (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd_start  (rd_start),
      .rd_loc    (rd_loc),
      .banks     (u_bank_if),
      .out_valid (out_valid),
      .out_last  (out_last),
      .out_data  (out_data),
      .busy      (busy)
   );

endmodule

// File: src/word_pkg.sv
package word_pkg;

   // one half-precision value, carried as raw bits
   typedef logic [15:0] word_t;

   // words held side by side in one bank location
   localparam int LANES = 4;

   typedef logic [LANES-1:0] lane_we_t;   // one write enable per word

endpackage

// File: src/wordwise_bram.sv
`timescale 1ns/1ps

module wordwise_bram (
   input logic clk,
   bank_if.bank port
);
   import word_pkg::*;
   import buf_pkg::*;

   localparam int DEPTH = 1 << LOC_AW;

   // 16 locations of LANES words each
   word_t [LANES-1:0] ram [DEPTH];

   // port A: each word lands only under its own enable
   always_ff @(posedge clk) begin
      for (int i = 0; i < LANES; i++) begin
         if (port.wr_we[i]) begin
            ram[port.wr_addr][i] <= port.wr_data[i];
         end
      end
   end

   // port B: registered read every edge
   // a same-edge write to this location is not seen, old words come out
   always_ff @(posedge clk) begin
      port.rd_data <= ram[port.rd_addr];
   end

   // streamer holds rd_addr under reset, so it must never float
   a_rd_addr_known: assert property (@(posedge clk) !$isunknown(port.rd_addr))
      else $error("bank read address unknown");

   // a loader write must always carry a defined location
   a_wr_addr_known: assert property (
      @(posedge clk) (|port.wr_we) |-> !$isunknown(port.wr_addr)
   ) else $error("bank write with unknown address");

endmodule

// File: verification/tb_word_buffer.sv
`timescale 1ns/1ps

module tb_word_buffer;
   import word_pkg::*;
   import buf_pkg::*;

   localparam int NUM_BANKS   = 4;
   localparam int ADDR_W      = 6 + $clog2(NUM_BANKS);
   localparam int LOCS        = 16;
   localparam int RAND_BURSTS = 20;
   localparam int MAX_LEN     = 40;
   localparam int OVL_BURSTS  = 12;
   localparam int OVL_READS   = 24;
   localparam int READ_CYC    = NUM_BANKS + 4;
   localparam int BUDGET      = 5 + 10 + (257 + LOCS * READ_CYC)
                              + RAND_BURSTS * (2 * MAX_LEN + 3) + LOCS * READ_CYC
                              + 3 * 12
                              + OVL_BURSTS * (2 * LOCS + 3) + OVL_READS * (READ_CYC + 4);

   logic              clk;
   logic              arst_n;
   logic              load_start;
   logic [ADDR_W-1:0] load_addr;
   logic              load_valid;
   word_t             load_data;
   logic              rd_start;
   loc_addr_t         rd_loc;
   logic              out_valid;
   logic              out_last;
   logic              busy;
   word_t [LANES-1:0] out_data;
   logic              exp_valid;
   logic              exp_last;
   logic              exp_busy;
   word_t [LANES-1:0] exp_data;
   logic [LANES-1:0]  exp_known;
   int                error_count = 0;
   int                check_count = 0;

   word_buffer_top #(.NUM_BANKS(NUM_BANKS)) u_word_buffer_top (
      .clk (clk), .arst_n (arst_n),
      .load_start (load_start), .load_addr (load_addr),
      .load_valid (load_valid), .load_data (load_data),
      .rd_start (rd_start), .rd_loc (rd_loc),
      .out_valid (out_valid), .out_last (out_last), .out_data (out_data), .busy (busy)
   );

   word_buffer_model #(.NUM_BANKS(NUM_BANKS)) u_word_buffer_model (
      .clk (clk), .arst_n (arst_n),
      .load_start (load_start), .load_addr (load_addr),
      .load_valid (load_valid), .load_data (load_data),
      .rd_start (rd_start), .rd_loc (rd_loc),
      .exp_valid (exp_valid), .exp_last (exp_last), .exp_busy (exp_busy),
      .exp_data (exp_data), .exp_known (exp_known)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
      check_count++;
      assert (act === exp) else begin
         $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
         error_count++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %s: %0d errors", name, error_count - errs_before);
   endtask

   // outputs settle between edges, compared at the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         check_value("out_valid", exp_valid, out_valid);
         check_value("out_last", exp_last, out_last);
         check_value("busy", exp_busy, busy);
         if (exp_valid) begin
            for (int l = 0; l < LANES; l++) begin
               if (exp_known[l]) begin   // unwritten words carry no value
                  check_value($sformatf("out_data[%0d]", l), exp_data[l], out_data[l]);
               end
            end
         end
      end
   end

   task automatic load_burst(input logic [ADDR_W-1:0] start, input int len,
                             input bit gaps, input bit split_start);
      if (split_start) begin
         @(posedge clk);
         load_start <= 1'b1;   // pointer only, no write
         load_addr  <= start;
      end
      for (int i = 0; i < len; i++) begin
         @(posedge clk);
         load_start <= (i == 0) && !split_start;
         load_addr  <= start;
         load_valid <= 1'b1;
         load_data  <= word_t'($urandom);
         if (gaps && $urandom_range(0, 1) == 1) begin
            @(posedge clk);
            load_start <= 1'b0;
            load_valid <= 1'b0;
         end
      end
      @(posedge clk);
      load_start <= 1'b0;
      load_valid <= 1'b0;
   endtask

   task automatic read_location(input loc_addr_t loc);
      bit got_last;
      int waited;
      got_last = 1'b0;
      @(posedge clk);
      rd_start <= 1'b1;
      rd_loc   <= loc;
      @(posedge clk);
      rd_start <= 1'b0;
      for (waited = 0; waited < READ_CYC && !got_last; waited++) begin
         @(negedge clk);
         got_last = out_last;
      end
      assert (got_last) else begin
         $display("read of location %0d gave no last beat within %0d cycles", loc, READ_CYC);
         error_count++;
      end
   endtask

   // two extra starts land while busy, the second on the final busy edge
   task automatic check_frame(input loc_addr_t loc);
      int n_valid;
      int first;
      int last;
      n_valid = 0;
      first   = -1;
      last    = -1;
      @(posedge clk);
      rd_start <= 1'b1;
      rd_loc   <= loc;
      @(posedge clk);
      rd_start <= 1'b0;
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         if (out_valid) begin
            n_valid++;
            if (first < 0) first = i;
         end
         if (out_last) last = i;
         @(posedge clk);
         rd_start <= (i == 0) || (i == 4);
      end
      check_value("beats per frame", NUM_BANKS, n_valid);
      check_value("first beat offset", 2, first);
      check_value("out_last offset", NUM_BANKS + 1, last);
   endtask

   initial begin
      int errs;
      int len;
      logic [ADDR_W-1:0] start;
      void'($urandom(32'h0d94_21a0));
      arst_n     = 1'b1;
      load_start = 1'b0;
      load_addr  = '0;
      load_valid = 1'b0;
      load_data  = '0;
      rd_start   = 1'b0;
      rd_loc     = '0;
      #1 arst_n = 1'b0;   // a real falling edge, after time zero
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;

      errs = error_count;
      repeat (10) begin
         @(negedge clk);
         check_value("out_valid", 1'b0, out_valid);
         check_value("out_last", 1'b0, out_last);
         check_value("busy", 1'b0, busy);
      end
      report_test("reset state", errs);

      errs = error_count;
      load_burst('0, 1 << ADDR_W, 1'b0, 1'b0);
      for (int loc = 0; loc < LOCS; loc++) read_location(loc_addr_t'(loc));
      report_test("full fill", errs);

      errs = error_count;
      for (int b = 0; b < RAND_BURSTS; b++) begin
         start = (b == 0) ? ADDR_W'((1 << ADDR_W) - 6) : ADDR_W'($urandom);   // first one wraps
         len   = (b == 0) ? 12 : $urandom_range(1, MAX_LEN);
         load_burst(start, len, 1'b1, b[0]);
      end
      for (int loc = 0; loc < LOCS; loc++) read_location(loc_addr_t'(loc));
      report_test("random bursts", errs);

      errs = error_count;
      for (int f = 0; f < 3; f++) check_frame(loc_addr_t'($urandom));
      report_test("stream framing", errs);

      errs = error_count;
      fork
         for (int b = 0; b < OVL_BURSTS; b++) begin
            load_burst(ADDR_W'($urandom_range(0, 1) * NUM_BANKS * LANES), NUM_BANKS * LANES,
                       1'b1, 1'b0);
         end
         for (int r = 0; r < OVL_READS; r++) begin
            read_location(loc_addr_t'($urandom_range(0, 1)));   // same locations as the loads
            repeat ($urandom_range(0, 3)) @(posedge clk);
         end
      join
      report_test("load during read", errs);

      $display("tests 5, checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      repeat (BUDGET * 12 / 10) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not complete", BUDGET * 12 / 10);
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: verification/word_buffer_model.sv
`timescale 1ns/1ps

module word_buffer_model #(
   parameter int NUM_BANKS = 4,
   parameter int ADDR_W    = 6 + $clog2(NUM_BANKS)
) (
   input  logic                                  clk,
   input  logic                                  arst_n,
   input  logic                                  load_start,
   input  logic [ADDR_W-1:0]                     load_addr,
   input  logic                                  load_valid,
   input  word_pkg::word_t                       load_data,
   input  logic                                  rd_start,
   input  buf_pkg::loc_addr_t                    rd_loc,
   output logic                                  exp_valid,
   output logic                                  exp_last,
   output logic                                  exp_busy,
   output word_pkg::word_t [word_pkg::LANES-1:0] exp_data,
   output logic [word_pkg::LANES-1:0]            exp_known
);
   import word_pkg::*;

   localparam int WORDS = 1 << ADDR_W;

   word_t             mem [WORDS];
   logic              known [WORDS];    // word written since reset
   word_t             snap [NUM_BANKS][LANES];
   logic              snap_ok [NUM_BANKS][LANES];
   logic [ADDR_W-1:0] ptr;
   logic [ADDR_W-1:0] cur;
   logic              pend;             // word accepted at the previous edge
   logic [ADDR_W-1:0] pend_addr;
   word_t             pend_data;
   int                cnt;              // edges since an accepted start, 0 when idle
   int                idx;
   int                beat;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr  = '0;
         pend = 1'b0;
         cnt  = 0;
         for (int i = 0; i < WORDS; i++) begin
            known[i] = 1'b0;
         end
         exp_valid <= 1'b0;
         exp_last  <= 1'b0;
         exp_busy  <= 1'b0;
         exp_known <= '0;
      end else begin
         if (pend) begin
            mem[pend_addr]   = pend_data;   // lands one edge after acceptance
            known[pend_addr] = 1'b1;
         end
         pend = 1'b0;

         // the snapshot holds every write up to and including this edge
         if (cnt == 0 && rd_start) begin
            for (int k = 0; k < NUM_BANKS; k++) begin
               for (int l = 0; l < LANES; l++) begin
                  idx = (int'(rd_loc) * NUM_BANKS + k) * LANES + l;   // {loc, bank, lane}
                  snap[k][l]    = mem[idx];
                  snap_ok[k][l] = known[idx];
               end
            end
            cnt = 1;
         end else if (cnt != 0) begin
            cnt = (cnt == NUM_BANKS + 2) ? 0 : cnt + 1;
         end

         cur = load_start ? load_addr : ptr;
         if (load_valid) begin
            pend      = 1'b1;
            pend_addr = cur;
            pend_data = load_data;
            ptr       = cur + 1'b1;   // wraps over the word space
         end else if (load_start) begin
            ptr = load_addr;
         end

         // first beat two edges after the start, one bank per beat
         exp_busy  <= (cnt != 0);
         exp_valid <= (cnt >= 3) && (cnt <= NUM_BANKS + 2);
         exp_last  <= (cnt == NUM_BANKS + 2);
         if (cnt >= 3 && cnt <= NUM_BANKS + 2) begin
            beat = cnt - 3;
            for (int l = 0; l < LANES; l++) begin
               exp_data[l]  <= snap[beat][l];
               exp_known[l] <= snap_ok[beat][l];
            end
         end
      end
   end

endmodule
